// ==== src/mrr_loopback_settings.svh ====
`ifndef MRR_LOOPBACK_SETTINGS_SVH
`define MRR_LOOPBACK_SETTINGS_SVH

// Sample stream and chip timing
`define MRR_SAMPLE_WIDTH 16
`define MRR_OVERSAMPLING 4
`define MRR_SYMBOL_CHIPS 6
`define MRR_TX_CHIPS 5
`define MRR_TX_BITS 32

// PN preamble and the offset search around it
`define MRR_PN_SEQ 15'b000100110101111
`define MRR_PN_LEN 15
`define MRR_SEARCH_SPAN 8
`define MRR_SEARCH_START 22
`define MRR_SYMBOL_RAM_DEPTH 32

// Datapath widths
`define MRR_SOFT_WIDTH 20
`define MRR_CORR_WIDTH 24

`endif

// ==== src/mrr_loopback_pkg.sv ====
`include "mrr_loopback_settings.svh"

package mrr_loopback_pkg;

    // Unsigned energy sample from the front end
    typedef logic [`MRR_SAMPLE_WIDTH-1:0] sample_t;

    // Chip-1 energy minus chip-3 energy of one received symbol
    typedef logic signed [`MRR_SOFT_WIDTH-1:0] soft_symbol_t;

    typedef enum logic [1:0] {
        LOOP_IDLE,
        LOOP_RECEIVE,
        LOOP_TRANSMIT
    } loop_state_t;

    typedef enum logic [2:0] {
        SEARCH_IDLE,
        SEARCH_ACCUM,
        SEARCH_DRAIN,
        SEARCH_COMPARE,
        SEARCH_DONE
    } search_state_t;

    typedef enum logic [1:0] {
        KEY_IDLE,
        KEY_TURNAROUND,
        KEY_BITS
    } key_state_t;

endpackage

// ==== src/chip_integrator.sv ====
`include "mrr_loopback_settings.svh"

module chip_integrator
    import mrr_loopback_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         i_rx_active,
    input  sample_t      i_sample,
    input  logic         i_sample_valid,
    output soft_symbol_t o_symbol,
    output logic         o_symbol_valid
);

    localparam int SAMP_CNT_W = $clog2(`MRR_OVERSAMPLING);
    localparam int CHIP_CNT_W = $clog2(`MRR_SYMBOL_CHIPS);
    localparam int ENERGY_W   = `MRR_SAMPLE_WIDTH + SAMP_CNT_W;
    localparam int PAD_W      = `MRR_SOFT_WIDTH - ENERGY_W;

    logic [SAMP_CNT_W-1:0]      samp_cnt;
    logic [CHIP_CNT_W-1:0]      chip_cnt;
    logic [ENERGY_W-1:0]        chip_accum;
    logic [ENERGY_W-1:0]        chip_energy;
    logic [ENERGY_W-1:0]        e1_energy;
    logic [`MRR_SOFT_WIDTH-1:0] e1_ext;
    logic [`MRR_SOFT_WIDTH-1:0] e3_ext;
    logic                       chip_end;

    // Energy of the current chip including the sample arriving this cycle
    assign chip_energy = chip_accum + ENERGY_W'(i_sample);
    assign chip_end    = i_rx_active && i_sample_valid
                         && (samp_cnt == SAMP_CNT_W'(`MRR_OVERSAMPLING - 1));

    assign e1_ext = {{PAD_W{1'b0}}, e1_energy};
    assign e3_ext = {{PAD_W{1'b0}}, chip_energy};

    // Counters restart whenever reception is not active, so the first
    // accepted sample after the trigger opens chip 0
    always_ff @(posedge clk) begin
        if (rst || !i_rx_active) begin
            samp_cnt       <= '0;
            chip_cnt       <= '0;
            chip_accum     <= '0;
            o_symbol_valid <= 1'b0;
        end else begin
            o_symbol_valid <= 1'b0;
            if (i_sample_valid) begin
                samp_cnt   <= chip_end ? '0 : samp_cnt + 1'b1;
                chip_accum <= chip_end ? '0 : chip_energy;
            end
            if (chip_end) begin
                if (chip_cnt == CHIP_CNT_W'(`MRR_SYMBOL_CHIPS - 1)) begin
                    chip_cnt       <= '0;
                    o_symbol_valid <= 1'b1;
                end else begin
                    chip_cnt <= chip_cnt + 1'b1;
                end
            end
        end
    end

    // The soft value is ready after chip 3 and is presented with the valid at the end of chip 5
    always_ff @(posedge clk) begin
        if (chip_end && (chip_cnt == CHIP_CNT_W'(1))) begin
            e1_energy <= chip_energy;
        end
        if (chip_end && (chip_cnt == CHIP_CNT_W'(3))) begin
            o_symbol <= e1_ext - e3_ext;
        end
    end

    // One symbol takes many samples, so valids can never touch
    assert property (@(posedge clk) disable iff (rst)
        o_symbol_valid |=> !o_symbol_valid);

endmodule

// ==== src/pn_offset_search.sv ====
`include "mrr_loopback_settings.svh"

module pn_offset_search
    import mrr_loopback_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  soft_symbol_t                        i_symbol,
    input  logic                                i_symbol_valid,
    input  logic                                i_clear,
    input  logic                                i_search_start,
    output logic [$clog2(`MRR_SEARCH_SPAN)-1:0] o_pn_offset,
    output logic                                o_pn_offset_valid
);

    localparam int ADDR_W = $clog2(`MRR_SYMBOL_RAM_DEPTH);
    localparam int OFF_W  = $clog2(`MRR_SEARCH_SPAN);
    localparam int SUB_W  = $clog2(`MRR_PN_LEN);
    localparam int SOFT_W = `MRR_SOFT_WIDTH;
    localparam int CORR_W = `MRR_CORR_WIDTH;

    soft_symbol_t             mem [`MRR_SYMBOL_RAM_DEPTH];
    logic [ADDR_W:0]          wr_addr;
    logic [ADDR_W-1:0]        rd_addr;
    soft_symbol_t             rd_data;
    logic                     rd_pending;
    search_state_t            state;
    logic [OFF_W-1:0]         offset;
    logic [OFF_W-1:0]         best_offset;
    logic [SUB_W-1:0]         sub_idx;
    logic [`MRR_PN_LEN-1:0]   pn_shift;
    logic signed [CORR_W-1:0] corr_sum;
    logic signed [CORR_W-1:0] best_sum;
    logic signed [CORR_W-1:0] rd_ext;

    assign rd_addr = ADDR_W'(offset) + ADDR_W'(sub_idx);
    assign rd_ext  = {{(CORR_W - SOFT_W){rd_data[SOFT_W-1]}}, rd_data};

    // Symbol RAM with a registered read port
    always_ff @(posedge clk) begin
        if (i_symbol_valid && !wr_addr[ADDR_W]) begin
            mem[wr_addr[ADDR_W-1:0]] <= i_symbol;
        end
        rd_data <= mem[rd_addr];
    end

    // Write address stops once the RAM is full
    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            wr_addr <= '0;
        end else if (i_symbol_valid && !wr_addr[ADDR_W]) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= SEARCH_IDLE;
            rd_pending        <= 1'b0;
            offset            <= '0;
            sub_idx           <= '0;
            o_pn_offset       <= '0;
            o_pn_offset_valid <= 1'b0;
        end else begin
            rd_pending        <= (state == SEARCH_ACCUM);
            o_pn_offset_valid <= 1'b0;
            case (state)
                SEARCH_IDLE: begin
                    if (i_search_start) begin
                        offset  <= '0;
                        sub_idx <= '0;
                        state   <= SEARCH_ACCUM;
                    end
                end
                SEARCH_ACCUM: begin
                    sub_idx <= sub_idx + 1'b1;
                    if (sub_idx == SUB_W'(`MRR_PN_LEN - 1)) begin
                        state <= SEARCH_DRAIN;
                    end
                end
                // Last read of this offset is still in flight
                SEARCH_DRAIN: begin
                    state <= SEARCH_COMPARE;
                end
                SEARCH_COMPARE: begin
                    sub_idx <= '0;
                    if (offset == OFF_W'(`MRR_SEARCH_SPAN - 1)) begin
                        state <= SEARCH_DONE;
                    end else begin
                        offset <= offset + 1'b1;
                        state  <= SEARCH_ACCUM;
                    end
                end
                SEARCH_DONE: begin
                    o_pn_offset       <= best_offset;
                    o_pn_offset_valid <= 1'b1;
                    state             <= SEARCH_IDLE;
                end
                default: begin
                    state <= SEARCH_IDLE;
                end
            endcase
        end
    end

    // Correlation datapath, one term per returned read with the PN bit taken MSB first
    always_ff @(posedge clk) begin
        if ((state == SEARCH_IDLE) && i_search_start) begin
            best_sum    <= '0;
            best_offset <= '0;
        end else if ((state == SEARCH_COMPARE) && (corr_sum > best_sum)) begin
            // Strict compare keeps the lowest offset on a tie and needs a positive sum
            best_sum    <= corr_sum;
            best_offset <= offset;
        end
        if ((state == SEARCH_IDLE) || (state == SEARCH_COMPARE)) begin
            corr_sum <= '0;
            pn_shift <= `MRR_PN_SEQ;
        end else if (rd_pending) begin
            pn_shift <= {pn_shift[`MRR_PN_LEN-2:0], 1'b0};
            corr_sum <= pn_shift[`MRR_PN_LEN-1] ? corr_sum - rd_ext : corr_sum + rd_ext;
        end
    end

    // The sequencer must not restart a search that is still running
    assert property (@(posedge clk) disable iff (rst)
        i_search_start |-> (state == SEARCH_IDLE));

endmodule

// ==== src/pulse_position_keyer.sv ====
`include "mrr_loopback_settings.svh"

module pulse_position_keyer
    import mrr_loopback_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_start,
    input  logic                    i_sample_valid,
    input  logic [15:0]             i_wait_chips,
    input  logic [`MRR_TX_BITS-1:0] i_tx_word,
    input  logic                    i_tx_disable,
    output logic                    o_tx_pulse,
    output logic                    o_done
);

    localparam int SAMP_CNT_W = $clog2(`MRR_OVERSAMPLING);
    localparam int BIT_CNT_W  = $clog2(`MRR_TX_BITS);

    key_state_t            state;
    logic [SAMP_CNT_W-1:0] samp_cnt;
    logic [15:0]           chip_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic                  chip_end;
    logic                  cur_bit;

    assign chip_end = i_sample_valid && (samp_cnt == SAMP_CNT_W'(`MRR_OVERSAMPLING - 1));
    assign cur_bit  = i_tx_word[bit_cnt];

    // A one is keyed in chip 0 of the bit, a zero in chip 2
    assign o_tx_pulse = (state == KEY_BITS) && !i_tx_disable
                        && (cur_bit ? (chip_cnt == 16'd0) : (chip_cnt == 16'd2));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= KEY_IDLE;
            samp_cnt <= '0;
            chip_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if ((state != KEY_IDLE) && i_sample_valid) begin
                samp_cnt <= chip_end ? '0 : samp_cnt + 1'b1;
            end
            case (state)
                KEY_IDLE: begin
                    if (i_start) begin
                        samp_cnt <= '0;
                        chip_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= (i_wait_chips == 16'd0) ? KEY_BITS : KEY_TURNAROUND;
                    end
                end
                KEY_TURNAROUND: begin
                    if (chip_end) begin
                        if (chip_cnt == i_wait_chips - 16'd1) begin
                            chip_cnt <= '0;
                            state    <= KEY_BITS;
                        end else begin
                            chip_cnt <= chip_cnt + 16'd1;
                        end
                    end
                end
                KEY_BITS: begin
                    if (chip_end) begin
                        if (chip_cnt == 16'(`MRR_TX_CHIPS - 1)) begin
                            chip_cnt <= '0;
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_CNT_W'(`MRR_TX_BITS - 1)) begin
                                state  <= KEY_IDLE;
                                o_done <= 1'b1;
                            end
                        end else begin
                            chip_cnt <= chip_cnt + 16'd1;
                        end
                    end
                end
                default: begin
                    state <= KEY_IDLE;
                end
            endcase
        end
    end

    // A new reply may only be requested once the previous one has finished
    assert property (@(posedge clk) disable iff (rst)
        i_start |-> (state == KEY_IDLE));

endmodule

// ==== src/loopback_sequencer.sv ====
`include "mrr_loopback_settings.svh"

module loopback_sequencer
    import mrr_loopback_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                i_trigger,
    input  logic                                i_symbol_valid,
    input  logic [7:0]                          i_num_payload_bits,
    input  logic [$clog2(`MRR_SEARCH_SPAN)-1:0] i_pn_offset,
    input  logic                                i_pn_offset_valid,
    input  logic                                i_key_done,
    output logic                                o_rx_active,
    output logic                                o_clear,
    output logic                                o_search_start,
    output logic                                o_soft_last,
    output logic                                o_key_start,
    output logic                                o_busy
);

    // Wide enough for the largest payload plus the largest offset
    localparam int CNT_W = 9;

    loop_state_t      state;
    logic [CNT_W-1:0] sym_cnt;
    logic [CNT_W-1:0] sym_cnt_next;
    logic [CNT_W-1:0] end_count;
    logic             search_done;

    assign sym_cnt_next = sym_cnt + 1'b1;
    assign end_count    = CNT_W'(i_num_payload_bits) + CNT_W'(i_pn_offset);

    assign o_rx_active    = (state == LOOP_RECEIVE);
    assign o_busy         = (state != LOOP_IDLE);
    assign o_clear        = (state == LOOP_IDLE);
    assign o_search_start = i_symbol_valid && (sym_cnt_next == CNT_W'(`MRR_SEARCH_START));

    // Reception ends on the symbol that completes the payload after the PN offset
    assign o_soft_last = i_symbol_valid && search_done && (sym_cnt_next == end_count);
    assign o_key_start = o_soft_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= LOOP_IDLE;
            sym_cnt     <= '0;
            search_done <= 1'b0;
        end else begin
            case (state)
                LOOP_IDLE: begin
                    sym_cnt     <= '0;
                    search_done <= 1'b0;
                    if (i_trigger) begin
                        state <= LOOP_RECEIVE;
                    end
                end
                LOOP_RECEIVE: begin
                    if (i_symbol_valid) begin
                        sym_cnt <= sym_cnt_next;
                    end
                    if (i_pn_offset_valid) begin
                        search_done <= 1'b1;
                    end
                    if (o_soft_last) begin
                        state <= LOOP_TRANSMIT;
                    end
                end
                LOOP_TRANSMIT: begin
                    if (i_key_done) begin
                        state <= LOOP_IDLE;
                    end
                end
                default: begin
                    state <= LOOP_IDLE;
                end
            endcase
        end
    end

    // Symbols only arrive while receiving, so the reply can only be started from there
    assert property (@(posedge clk) disable iff (rst)
        o_key_start |-> (state == LOOP_RECEIVE));

endmodule

// ==== src/mrr_loopback.sv ====
`include "mrr_loopback_settings.svh"

module mrr_loopback
    import mrr_loopback_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  sample_t                             i_sample,
    input  logic                                i_sample_valid,
    input  logic                                i_trigger,
    input  logic [7:0]                          i_num_payload_bits,
    input  logic [15:0]                         i_wait_chips,
    input  logic [`MRR_TX_BITS-1:0]             i_tx_word,
    input  logic                                i_tx_disable,
    output soft_symbol_t                        o_soft_symbol,
    output logic                                o_soft_valid,
    output logic                                o_soft_last,
    output logic [$clog2(`MRR_SEARCH_SPAN)-1:0] o_pn_offset,
    output logic                                o_pn_offset_valid,
    output logic                                o_tx_pulse,
    output logic                                o_busy
);

    logic rx_active;
    logic clear;
    logic search_start;
    logic key_start;
    logic key_done;

    chip_integrator chip_integrator_inst (
        .clk            (clk),
        .rst            (rst),
        .i_rx_active    (rx_active),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .o_symbol       (o_soft_symbol),
        .o_symbol_valid (o_soft_valid)
    );

    pn_offset_search pn_offset_search_inst (
        .clk               (clk),
        .rst               (rst),
        .i_symbol          (o_soft_symbol),
        .i_symbol_valid    (o_soft_valid),
        .i_clear           (clear),
        .i_search_start    (search_start),
        .o_pn_offset       (o_pn_offset),
        .o_pn_offset_valid (o_pn_offset_valid)
    );

    pulse_position_keyer pulse_position_keyer_inst (
        .clk            (clk),
        .rst            (rst),
        .i_start        (key_start),
        .i_sample_valid (i_sample_valid),
        .i_wait_chips   (i_wait_chips),
        .i_tx_word      (i_tx_word),
        .i_tx_disable   (i_tx_disable),
        .o_tx_pulse     (o_tx_pulse),
        .o_done         (key_done)
    );

    loopback_sequencer loopback_sequencer_inst (
        .clk                (clk),
        .rst                (rst),
        .i_trigger          (i_trigger),
        .i_symbol_valid     (o_soft_valid),
        .i_num_payload_bits (i_num_payload_bits),
        .i_pn_offset        (o_pn_offset),
        .i_pn_offset_valid  (o_pn_offset_valid),
        .i_key_done         (key_done),
        .o_rx_active        (rx_active),
        .o_clear            (clear),
        .o_search_start     (search_start),
        .o_soft_last        (o_soft_last),
        .o_key_start        (key_start),
        .o_busy             (o_busy)
    );

endmodule

// ==== dv/mrr_loopback_tb.sv ====
`include "mrr_loopback_settings.svh"

module mrr_loopback_tb
    import mrr_loopback_pkg::*;
();

    localparam int NUM_TESTS = 12;
    localparam int FIELDS    = 6;
    localparam int SYM_SAMPS = `MRR_SYMBOL_CHIPS * `MRR_OVERSAMPLING;
    localparam int BIT_SAMPS = `MRR_TX_CHIPS * `MRR_OVERSAMPLING;
    localparam int PH_IDLE   = 0;
    localparam int PH_RX     = 1;
    localparam int PH_TX     = 2;
    localparam int PH_DRAIN  = 3;

    logic                                clk;
    logic                                rst;
    sample_t                             i_sample;
    logic                                i_sample_valid;
    logic                                i_trigger;
    logic [7:0]                          i_num_payload_bits;
    logic [15:0]                         i_wait_chips;
    logic [`MRR_TX_BITS-1:0]             i_tx_word;
    logic                                i_tx_disable;
    soft_symbol_t                        o_soft_symbol;
    logic                                o_soft_valid;
    logic                                o_soft_last;
    logic [$clog2(`MRR_SEARCH_SPAN)-1:0] o_pn_offset;
    logic                                o_pn_offset_valid;
    logic                                o_tx_pulse;
    logic                                o_busy;

    logic [31:0] tests [NUM_TESTS*FIELDS];
    sample_t     samples [$];
    int          exp_soft [$];
    int          phase;
    int          soft_idx;
    int          end_count;
    int          tx_idx;
    int          tx_total;
    int          drain_cnt;
    int          offset_seen;
    int          model_offset;
    int          cycle_count;
    int          timeout_limit;
    int          err_soft;
    int          err_offset;
    int          err_last;
    int          err_tx;
    int          err_busy;
    int          err_other;
    bit          reply_done;
    bit          monitor_on;

    mrr_loopback mrr_loopback_inst (
        .clk                (clk),
        .rst                (rst),
        .i_sample           (i_sample),
        .i_sample_valid     (i_sample_valid),
        .i_trigger          (i_trigger),
        .i_num_payload_bits (i_num_payload_bits),
        .i_wait_chips       (i_wait_chips),
        .i_tx_word          (i_tx_word),
        .i_tx_disable       (i_tx_disable),
        .o_soft_symbol      (o_soft_symbol),
        .o_soft_valid       (o_soft_valid),
        .o_soft_last        (o_soft_last),
        .o_pn_offset        (o_pn_offset),
        .o_pn_offset_valid  (o_pn_offset_valid),
        .o_tx_pulse         (o_tx_pulse),
        .o_busy             (o_busy)
    );

    always #4 clk = ~clk;

    // Each PN chip becomes a strong chip-1 or chip-3 energy and every other symbol is random
    task automatic build_symbols(input int off, input int n_sym);
        logic [`MRR_PN_LEN-1:0] pn;
        int                     energy [`MRR_SYMBOL_CHIPS];
        int                     strong_chip;
        int                     n;
        int                     c;
        int                     k;
        sample_t                s;
        pn = `MRR_PN_SEQ;
        samples.delete();
        exp_soft.delete();
        for (n = 0; n < n_sym; n++) begin
            strong_chip = -1;
            if (n >= off && n < off + `MRR_PN_LEN) begin
                strong_chip = pn[`MRR_PN_LEN-1-(n-off)] ? 3 : 1;
            end
            for (c = 0; c < `MRR_SYMBOL_CHIPS; c++) begin
                energy[c] = 0;
                for (k = 0; k < `MRR_OVERSAMPLING; k++) begin
                    s = sample_t'($urandom_range(1023));
                    if (c == strong_chip) begin
                        s = s + 16'd12000;
                    end
                    energy[c] += s;
                    samples.push_back(s);
                end
            end
            exp_soft.push_back(energy[1] - energy[3]);
        end
    endtask

    // Picks the lowest offset with the largest positive correlation where a PN bit of 1 subtracts
    function automatic int find_offset();
        logic [`MRR_PN_LEN-1:0] pn;
        int                     best;
        int                     best_sum;
        int                     sum;
        int                     off;
        int                     k;
        pn = `MRR_PN_SEQ;
        best = 0;
        best_sum = 0;
        for (off = 0; off < `MRR_SEARCH_SPAN; off++) begin
            sum = 0;
            for (k = 0; k < `MRR_PN_LEN; k++) begin
                sum += pn[`MRR_PN_LEN-1-k] ? -exp_soft[off+k] : exp_soft[off+k];
            end
            if (sum > best_sum) begin
                best_sum = sum;
                best = off;
            end
        end
        return best;
    endfunction

    // Expected pulse for the given accepted sample after the last soft symbol
    function automatic logic tx_expected(input int idx);
        int   j;
        int   chip;
        logic b;
        if (i_tx_disable || idx < int'(i_wait_chips) * `MRR_OVERSAMPLING) begin
            return 1'b0;
        end
        j = idx - int'(i_wait_chips) * `MRR_OVERSAMPLING;
        b = i_tx_word[j / BIT_SAMPS];
        chip = (j % BIT_SAMPS) / `MRR_OVERSAMPLING;
        return b ? (chip == 0) : (chip == 2);
    endfunction

    task automatic drive_gap_or_sample(input int gap, input sample_t s, inout int idx);
        if ($urandom_range(99) < gap) begin
            i_sample_valid <= 1'b0;
            i_sample       <= sample_t'($urandom);
        end else begin
            i_sample_valid <= 1'b1;
            i_sample       <= s;
            idx++;
        end
    endtask

    task automatic run_test(input int t);
        int off;
        int payload;
        int gap;
        int idx;
        int cyc;
        off = tests[t*FIELDS];
        payload = tests[t*FIELDS+1];
        gap = tests[t*FIELDS+5];
        build_symbols(off, payload + off + 4);
        model_offset = find_offset();
        if (model_offset != off) begin
            err_other++;
            $display("Test %0d plants offset %0d but the model picks %0d", t, off, model_offset);
        end
        end_count = off + payload;
        tx_total = tests[t*FIELDS+2] * `MRR_OVERSAMPLING + `MRR_TX_BITS * BIT_SAMPS;
        soft_idx = 0;
        offset_seen = 0;
        reply_done = 1'b0;
        @(posedge clk);
        i_num_payload_bits <= 8'(payload);
        i_wait_chips       <= tests[t*FIELDS+2][15:0];
        i_tx_word          <= tests[t*FIELDS+3];
        i_tx_disable       <= tests[t*FIELDS+4][0];
        i_trigger          <= 1'b1;
        i_sample_valid     <= 1'b0;
        idx = 0;
        cyc = 0;
        while (idx < samples.size()) begin
            @(posedge clk);
            phase = (cyc == 0) ? PH_RX : phase;
            // A trigger while busy must be ignored
            i_trigger <= (cyc == 300);
            drive_gap_or_sample(gap, samples[idx], idx);
            cyc++;
        end
        cyc = 0;
        while (!reply_done) begin
            @(posedge clk);
            i_trigger <= (cyc == 50);
            drive_gap_or_sample(gap, sample_t'($urandom), idx);
            cyc++;
        end
        @(posedge clk);
        i_sample_valid <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (offset_seen != 1) begin
            err_offset++;
            $display("Test %0d saw the offset valid %0d times instead of once", t, offset_seen);
        end
        if (o_pn_offset !== 3'(off)) begin
            err_offset++;
            $display("FAILED @%0t: held offset %0d, expected %0d", $time, o_pn_offset, off);
        end
        if (soft_idx != end_count) begin
            err_last++;
            $display("Test %0d received %0d soft symbols, expected %0d", t, soft_idx, end_count);
        end
    endtask

    task automatic print_counts();
        $display("Error counts: soft=%0d offset=%0d last=%0d tx=%0d busy=%0d other=%0d",
                 err_soft, err_offset, err_last, err_tx, err_busy, err_other);
    endtask

    always @(negedge clk) begin
        if (monitor_on) begin
            if (o_pn_offset_valid) begin
                offset_seen++;
                if (o_pn_offset !== 3'(model_offset)) begin
                    err_offset++;
                    $display("FAILED @%0t: offset %0d, expected %0d", $time, o_pn_offset,
                             model_offset);
                end
            end
            case (phase)
                PH_IDLE: begin
                    if (o_busy !== 1'b0 || o_soft_valid !== 1'b0 || o_tx_pulse !== 1'b0) begin
                        err_busy++;
                        $display("FAILED @%0t: outputs active while the DUT is idle",
                                 $time);
                    end
                end
                PH_RX: begin
                    if (o_busy !== 1'b1) begin
                        err_busy++;
                        $display("FAILED @%0t: busy is low during reception", $time);
                    end
                    if (o_tx_pulse !== 1'b0) begin
                        err_tx++;
                        $display("FAILED @%0t: pulse keyed during reception", $time);
                    end
                    if (o_soft_last && !o_soft_valid) begin
                        err_last++;
                        $display("FAILED @%0t: soft last without a soft symbol", $time);
                    end
                    if (o_soft_valid) begin
                        if (soft_idx >= end_count) begin
                            err_last++;
                            $display("FAILED @%0t: soft symbol after the expected last one",
                                     $time);
                        end else begin
                            if (o_soft_symbol !== soft_symbol_t'(exp_soft[soft_idx])) begin
                                err_soft++;
                                $display("FAILED @%0t: soft symbol %0d is %0d, expected %0d",
                                         $time, soft_idx, o_soft_symbol, exp_soft[soft_idx]);
                            end
                            if (o_soft_last !== (soft_idx == end_count - 1)) begin
                                err_last++;
                                $display("FAILED @%0t: soft last is %0b on symbol %0d", $time,
                                         o_soft_last, soft_idx);
                            end
                        end
                        soft_idx++;
                        if (o_soft_last) begin
                            phase = PH_TX;
                            tx_idx = 0;
                        end
                    end
                end
                PH_TX: begin
                    if (o_busy !== 1'b1 || o_soft_valid !== 1'b0) begin
                        err_busy++;
                        $display("FAILED @%0t: busy low or a soft symbol seen while replying",
                                 $time);
                    end
                    // The pulse holds for the whole chip including gap cycles
                    if (o_tx_pulse !== tx_expected(tx_idx)) begin
                        err_tx++;
                        $display("FAILED @%0t: pulse %0b at reply sample %0d", $time,
                                 o_tx_pulse, tx_idx);
                    end
                    if (i_sample_valid) begin
                        tx_idx++;
                        if (tx_idx == tx_total) begin
                            phase = PH_DRAIN;
                            drain_cnt = 0;
                        end
                    end
                end
                PH_DRAIN: begin
                    drain_cnt++;
                    if (o_tx_pulse !== 1'b0) begin
                        err_tx++;
                        $display("FAILED @%0t: pulse after the last reply bit", $time);
                    end
                    if (o_busy === 1'b0) begin
                        phase = PH_IDLE;
                        reply_done = 1'b1;
                    end else if (drain_cnt > 3) begin
                        err_busy++;
                        $display("Busy did not fall after the last reply bit at %0t", $time);
                        phase = PH_IDLE;
                        reply_done = 1'b1;
                    end
                end
                default: begin
                    phase = PH_IDLE;
                end
            endcase
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", timeout_limit);
            print_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_sample = '0;
        i_sample_valid = 1'b0;
        i_trigger = 1'b0;
        i_num_payload_bits = 8'd30;
        i_wait_chips = '0;
        i_tx_word = '0;
        i_tx_disable = 1'b0;
        phase = PH_IDLE;
        monitor_on = 1'b0;
        cycle_count = 0;
        void'($urandom(53));
        $readmemh("dv/mrr_loopback_tests.txt", tests);
        timeout_limit = 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if ($isunknown(tests[t*FIELDS]) || tests[t*FIELDS] >= `MRR_SEARCH_SPAN
                || tests[t*FIELDS+1] < 30 || tests[t*FIELDS+1] > 200
                || tests[t*FIELDS+5] > 35 || $isunknown(tests[t*FIELDS+3])) begin
                err_other++;
                $display("Test %0d in the data file holds unusable parameters", t);
            end else begin
                timeout_limit += 2 * ((tests[t*FIELDS+1] + tests[t*FIELDS] + 4) * SYM_SAMPS
                    + (tests[t*FIELDS+2] + `MRR_TX_BITS * `MRR_TX_CHIPS) * `MRR_OVERSAMPLING
                    + 300);
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        monitor_on = 1'b1;
        if (err_other == 0) begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_test(t);
            end
        end
        print_counts();
        if (err_soft + err_offset + err_last + err_tx + err_busy + err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== mrr_loopback.f ====
+incdir+src
src/mrr_loopback_pkg.sv
src/chip_integrator.sv
src/pn_offset_search.sv
src/pulse_position_keyer.sv
src/loopback_sequencer.sv
src/mrr_loopback.sv
dv/mrr_loopback_tb.sv

// ==== Bender.yml ====
package:
  name: mrr_loopback

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/mrr_loopback_pkg.sv
      - src/chip_integrator.sv
      - src/pn_offset_search.sv
      - src/pulse_position_keyer.sv
      - src/loopback_sequencer.sv
      - src/mrr_loopback.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/mrr_loopback_tb.sv

// ==== dv/mrr_loopback_tests.txt ====
// offset payload_bits wait_chips reply_word tx_disable gap_percent
// All fields are hex, one test per line
0 1e 0000 00000001 0 00
7 c8 0003 ffffffff 0 00
3 40 0010 a5c3f00d 0 14
5 2d 0001 12345678 1 0a
1 20 0000 80000000 0 23
2 64 0008 deadbeef 0 05
6 1f 0002 00000000 0 19
4 32 0020 5a5a5a5a 1 00
0 50 0004 c0ffee11 0 1e
7 21 0000 0f0f0f0f 0 0f
3 80 0040 13579bdf 0 0a
1 3c 0005 2468ace0 0 1e
